// File: design/noc_pkg.sv
// noc package for the vc router input port
// flit, route and buffer-entry types plus the port numbering
`default_nettype none

package noc_pkg;

   // --------------------
   // flit format
   localparam int FLIT_DW = 32;      // flit payload width

   // destination fields inside a head flit
   localparam int DSTX_LSB = 8;      // data[15:8]
   localparam int DSTY_LSB = 0;      // data[7:0]

   typedef logic [7:0] coord_t;      // router coordinate

   typedef struct packed {
      logic hof;                     // head of frame
      logic bof;                     // body
      logic eof;                     // end of frame
   } flit_type_t;

   typedef struct packed {
      flit_type_t         ftype;
      logic [FLIT_DW-1:0] data;
   } flit_t;

   // --------------------
   // router ports
   localparam int NPORT = 5;

   localparam int PORT_SOUTH = 0;
   localparam int PORT_WEST  = 1;
   localparam int PORT_NORTH = 2;
   localparam int PORT_EAST  = 3;
   localparam int PORT_LOCAL = 4;

   // one-hot guide toward the switch
   typedef logic [NPORT-1:0] route_t;

   // --------------------
   // what one vc fifo slot holds
   // route only meaningful on head flits
   typedef struct packed {
      flit_t  flit;
      route_t route;
   } buf_entry_t;

endpackage

`default_nettype wire

// File: design/flit_receiver.sv
// flit receiver of the input port
// steers flits to their vc fifo and attaches the xy route to head flits
`timescale 1ns/1ps
`default_nettype none

module flit_receiver #(
   parameter int VCN = 2,
   parameter int VW  = (VCN > 1) ? $clog2(VCN) : 1
) (
   input  wire logic               clk,
   input  wire logic               rst,
   input  wire logic               in_valid,
   input  wire logic [VW-1:0]      in_vc,
   input  noc_pkg::flit_t          in_flit,
   input  noc_pkg::coord_t         router_x,
   input  noc_pkg::coord_t         router_y,
   input  wire logic [VCN-1:0]     fifo_full,
   output logic [VCN-1:0]          wr_en,
   output noc_pkg::buf_entry_t     wr_entry,
   output logic                    overflow_err
);

   logic [VCN-1:0]   vc_sel;     // decoded target vc
   noc_pkg::coord_t  dst_x;
   noc_pkg::coord_t  dst_y;
   noc_pkg::route_t  xy_route;

   // --------------------
   // vc decode
   for (genvar v = 0; v < VCN; v++) begin : g_sel
      assign vc_sel[v] = in_valid && (in_vc == VW'(v));
   end

   assign wr_en = vc_sel & ~fifo_full;   // drop writes to a full fifo

   // --------------------
   // dimension-order routing, x first
   assign dst_x = in_flit.data[noc_pkg::DSTX_LSB +: 8];
   assign dst_y = in_flit.data[noc_pkg::DSTY_LSB +: 8];

   always_comb begin
      xy_route = '0;
      if (dst_x > router_x)
         xy_route[noc_pkg::PORT_EAST] = 1'b1;
      else if (dst_x < router_x)
         xy_route[noc_pkg::PORT_WEST] = 1'b1;
      else if (dst_y > router_y)
         xy_route[noc_pkg::PORT_NORTH] = 1'b1;
      else if (dst_y < router_y)
         xy_route[noc_pkg::PORT_SOUTH] = 1'b1;
      else
         xy_route[noc_pkg::PORT_LOCAL] = 1'b1;   // arrived
   end

   always_comb begin
      wr_entry.flit  = in_flit;
      wr_entry.route = in_flit.ftype.hof ? xy_route : '0;
   end

   // sticky flag, upstream broke the credit rule
   always_ff @(posedge clk) begin
      if (rst)
         overflow_err <= 1'b0;
      else if (|(vc_sel & fifo_full))
         overflow_err <= 1'b1;
   end

endmodule

`default_nettype wire

// File: design/vc_fifo.sv
// vc fifo
// circular buffer of entries for one vc with a registered head
`timescale 1ns/1ps
`default_nettype none

module vc_fifo #(
   parameter int DEPTH = 4,
   parameter int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1,
   parameter int CW    = $clog2(DEPTH + 1)
) (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire logic           wr_en,
   input  wire logic           rd_en,
   input  noc_pkg::buf_entry_t wr_entry,
   output noc_pkg::buf_entry_t head_entry,
   output logic                full,
   output logic                empty
);

   noc_pkg::buf_entry_t mem [DEPTH];
   logic [AW-1:0]       wr_ptr;
   logic [AW-1:0]       rd_ptr;
   logic [AW-1:0]       rd_nxt;     // slot behind the head
   logic [CW-1:0]       count;
   logic                do_wr;
   logic                do_rd;

   assign full   = (count == CW'(DEPTH));
   assign empty  = (count == '0);
   assign do_wr  = wr_en && !full;
   assign do_rd  = rd_en && !empty;
   assign rd_nxt = (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

   // pointers and occupancy
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_nxt;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // storage and head register
   always_ff @(posedge clk) begin
      if (do_wr)
         mem[wr_ptr] <= wr_entry;
      if (do_wr && (empty || (count == CW'(1) && do_rd)))
         head_entry <= wr_entry;           // new flit goes straight to the head
      else if (do_rd)
         head_entry <= mem[rd_nxt];
   end

endmodule

`default_nettype wire

// File: design/vc_output.sv
// vc output stage
// requests the switch, pops on a grant and returns one credit per flit
`timescale 1ns/1ps
`default_nettype none

module vc_output (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire logic           empty,
   input  noc_pkg::buf_entry_t head_entry,
   input  wire logic           sw_gnt,
   output logic                rd_en,
   output logic                sw_req,
   output noc_pkg::route_t     sw_port,
   output logic                out_valid,
   output noc_pkg::flit_t      out_flit,
   output logic                credit_out
);

   noc_pkg::route_t pkt_route;     // route of the packet in progress
   logic            pending;       // flit on the output this cycle
   logic            head_flit;

   assign head_flit = head_entry.flit.ftype.hof;

   // --------------------
   // request side
   assign sw_req  = !empty && !pending;
   assign sw_port = head_flit ? head_entry.route : pkt_route;
   assign rd_en   = sw_gnt && sw_req;   // stray grants ignored

   // latch the head's guide for body and end flits
   always_ff @(posedge clk) begin
      if (rst)
         pkt_route <= '0;
      else if (rd_en && head_flit)
         pkt_route <= head_entry.route;
   end

   // --------------------
   // output register
   always_ff @(posedge clk) begin
      if (rst)
         pending <= 1'b0;
      else
         pending <= rd_en;
   end

   always_ff @(posedge clk) begin
      if (rd_en)
         out_flit <= head_entry.flit;
   end

   // flit leaves and its slot is freed in the same cycle
   assign out_valid  = pending;
   assign credit_out = pending;

endmodule

`default_nettype wire

// File: design/input_buffer.sv
// input buffer of one vc router port
// receiver, per-vc fifos and per-vc output stages
`timescale 1ns/1ps
`default_nettype none

module input_buffer #(
   parameter int VCN   = 2,
   parameter int DEPTH = 4,
   parameter int VW    = (VCN > 1) ? $clog2(VCN) : 1
) (
   input  wire logic                        clk,
   input  wire logic                        rst,
   input  wire logic                        in_valid,
   input  wire logic [VW-1:0]               in_vc,
   input  noc_pkg::flit_t                   in_flit,
   input  noc_pkg::coord_t                  router_x,
   input  noc_pkg::coord_t                  router_y,
   input  wire logic [VCN-1:0]              sw_gnt,
   output logic [VCN-1:0]                   sw_req,
   output noc_pkg::route_t [VCN-1:0]        sw_port,
   output logic [VCN-1:0]                   out_valid,
   output noc_pkg::flit_t [VCN-1:0]         out_flit,
   output logic [VCN-1:0]                   credit_out,
   output logic                             overflow_err
);

   logic [VCN-1:0]                  wr_en;
   logic [VCN-1:0]                  rd_en;
   logic [VCN-1:0]                  fifo_full;
   logic [VCN-1:0]                  fifo_empty;
   noc_pkg::buf_entry_t             wr_entry;     // shared by all fifos
   noc_pkg::buf_entry_t [VCN-1:0]   head_entry;

   flit_receiver #(.VCN(VCN), .VW(VW)) rx0 (
      .clk          (clk),
      .rst          (rst),
      .in_valid     (in_valid),
      .in_vc        (in_vc),
      .in_flit      (in_flit),
      .router_x     (router_x),
      .router_y     (router_y),
      .fifo_full    (fifo_full),
      .wr_en        (wr_en),
      .wr_entry     (wr_entry),
      .overflow_err (overflow_err)
   );

   // --------------------
   // one fifo and one output stage per vc
   for (genvar v = 0; v < VCN; v++) begin : g_vc
      vc_fifo #(.DEPTH(DEPTH)) fifo (
         .clk        (clk),
         .rst        (rst),
         .wr_en      (wr_en[v]),
         .rd_en      (rd_en[v]),
         .wr_entry   (wr_entry),
         .head_entry (head_entry[v]),
         .full       (fifo_full[v]),
         .empty      (fifo_empty[v])
      );

      vc_output outp (
         .clk        (clk),
         .rst        (rst),
         .empty      (fifo_empty[v]),
         .head_entry (head_entry[v]),
         .sw_gnt     (sw_gnt[v]),
         .rd_en      (rd_en[v]),
         .sw_req     (sw_req[v]),
         .sw_port    (sw_port[v]),
         .out_valid  (out_valid[v]),
         .out_flit   (out_flit[v]),
         .credit_out (credit_out[v])
      );
   end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
// clock and reset generator for the input buffer testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD     = 20,
   parameter int RST_CYCLES = 8
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // synchronous reset, released on a rising edge
   initial begin
      rst <= 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire

// File: tb/input_buffer_tb.sv
// testbench for the vc router input buffer
// directed tests checked against an xy routing model and per-vc expected queues
`timescale 1ns/1ps
`default_nettype none

module input_buffer_tb;

   localparam int VCN = 2;
   localparam int DEPTH = 4;
   localparam int VW = 1;
   localparam int WATCHDOG_CYCLES = 200 * 6 + 100;   // six tests plus margin
   localparam noc_pkg::coord_t ROUTER_X = 8'd3;
   localparam noc_pkg::coord_t ROUTER_Y = 8'd3;
   localparam logic [VW-1:0] VC0 = 1'b0;
   localparam logic [VW-1:0] VC1 = 1'b1;
   localparam logic [2:0] HEAD = 3'b100;              // hof, bof, eof
   localparam logic [2:0] BODY = 3'b010;
   localparam logic [2:0] TAIL = 3'b001;
   localparam logic [2:0] SINGLE = 3'b101;

   typedef struct packed {
      noc_pkg::flit_t  flit;
      noc_pkg::route_t port;                          // sw_port expected with it
   } expect_t;

   logic                      clk;
   logic                      rst;
   logic                      in_valid;
   logic [VW-1:0]             in_vc;
   noc_pkg::flit_t            in_flit;
   noc_pkg::coord_t           router_x;
   noc_pkg::coord_t           router_y;
   logic [VCN-1:0]            sw_gnt;
   logic [VCN-1:0]            sw_req;
   noc_pkg::route_t [VCN-1:0] sw_port;
   logic [VCN-1:0]            out_valid;
   noc_pkg::flit_t [VCN-1:0]  out_flit;
   logic [VCN-1:0]            credit_out;
   logic                      overflow_err;

   expect_t         exp_q [VCN][$];                   // flits stored per vc
   noc_pkg::route_t cur_route [VCN];                  // route of the open packet
   string           test_name;
   int              errors = 0;
   int              tests_run = 0;
   int              credits_seen [VCN];               // credit pulses per vc
   int              valids_seen [VCN];                // out_valid pulses per vc

   assign router_x = ROUTER_X;
   assign router_y = ROUTER_Y;

   tb_clock #(.PERIOD(20), .RST_CYCLES(8)) clk0 (.clk(clk), .rst(rst));

   input_buffer #(.VCN(VCN), .DEPTH(DEPTH)) dut0 (.*);

   // every output pulse is counted, not just the ones a grant expects
   always @(negedge clk) begin
      for (int v = 0; v < VCN; v++) begin
         if (credit_out[v] === 1'b1)
            credits_seen[v]++;
         if (out_valid[v] === 1'b1)
            valids_seen[v]++;
      end
   end

   // --------------------
   // model and helpers
   function automatic noc_pkg::route_t xy_port(input noc_pkg::coord_t dx,
                                               input noc_pkg::coord_t dy);
      noc_pkg::route_t r;
      r = '0;
      if (dx > ROUTER_X) r[noc_pkg::PORT_EAST] = 1'b1;
      else if (dx < ROUTER_X) r[noc_pkg::PORT_WEST] = 1'b1;
      else if (dy > ROUTER_Y) r[noc_pkg::PORT_NORTH] = 1'b1;
      else if (dy < ROUTER_Y) r[noc_pkg::PORT_SOUTH] = 1'b1;
      else r[noc_pkg::PORT_LOCAL] = 1'b1;
      return r;
   endfunction

   // random payload with the destination in the low bytes of head flits
   function automatic noc_pkg::flit_t make_flit(input logic [2:0] kind,
                                                input noc_pkg::coord_t dx,
                                                input noc_pkg::coord_t dy);
      logic [31:0] r;
      r = $urandom;
      return {kind, kind[2] ? {r[31:16], dx, dy} : r};
   endfunction

   task automatic mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
      errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
   endtask

   task automatic start_test(input string name);
      test_name = name;
      tests_run++;
      $display("running %s", name);
   endtask

   task automatic send_flit(input logic [VW-1:0] vc, input noc_pkg::flit_t f);
      expect_t e;
      if (exp_q[vc].size() < DEPTH) begin            // a full vc drops the flit
         if (f.ftype.hof)
            cur_route[vc] = xy_port(f.data[15:8], f.data[7:0]);
         e.flit = f;
         e.port = cur_route[vc];
         exp_q[vc].push_back(e);
      end
      @(posedge clk);
      in_valid <= 1'b1;
      in_vc    <= vc;
      in_flit  <= f;
      @(posedge clk);
      in_valid <= 1'b0;
   endtask

   task automatic wait_req(input logic [VW-1:0] vc);
      int n;
      n = 0;
      @(negedge clk);
      while (sw_req[vc] !== 1'b1 && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (sw_req[vc] !== 1'b1) begin
         errors++;
         $display("[ERROR] %s: sw_req on vc %0d never rose", test_name, vc);
      end
   endtask

   // grant one flit and check the output cycle and the cycle after it
   task automatic grant(input logic [VW-1:0] vc);
      expect_t e;
      wait_req(vc);
      if (exp_q[vc].size() == 0) begin
         errors++;
         $display("[ERROR] %s: grant on vc %0d with no flit expected", test_name, vc);
      end else begin
         e = exp_q[vc].pop_front();
         if (sw_port[vc] !== e.port) mismatch("sw_port", 64'(e.port), 64'(sw_port[vc]));
         @(posedge clk);
         sw_gnt <= VCN'(1) << vc;
         @(posedge clk);                              // grant sampled here
         sw_gnt <= '0;
         @(negedge clk);
         if (out_valid[vc] !== 1'b1) mismatch("out_valid", 64'(1), 64'(out_valid[vc]));
         if (credit_out[vc] !== 1'b1) mismatch("credit_out", 64'(1), 64'(credit_out[vc]));
         if (out_flit[vc] !== e.flit) mismatch("out_flit", 64'(e.flit), 64'(out_flit[vc]));
         if (sw_req[vc] !== 1'b0) mismatch("sw_req", 64'(0), 64'(sw_req[vc]));
         if ((out_valid & ~(VCN'(1) << vc)) !== '0) mismatch("other out_valid", 64'(0), 64'(out_valid));
         @(negedge clk);
         if (out_valid[vc] !== 1'b0) mismatch("out_valid after", 64'(0), 64'(out_valid[vc]));
         if (credit_out[vc] !== 1'b0) mismatch("credit_out after", 64'(0), 64'(credit_out[vc]));
      end
   endtask

   task automatic route_one(input noc_pkg::coord_t dx, input noc_pkg::coord_t dy);
      send_flit(VC0, make_flit(SINGLE, dx, dy));
      grant(VC0);
   endtask

   // --------------------
   // directed tests
   task automatic reset_state();
      start_test("reset_state");
      @(negedge clk);
      if (sw_req !== '0) mismatch("sw_req", 64'(0), 64'(sw_req));
      if (out_valid !== '0) mismatch("out_valid", 64'(0), 64'(out_valid));
      if (credit_out !== '0) mismatch("credit_out", 64'(0), 64'(credit_out));
      if (overflow_err !== 1'b0) mismatch("overflow_err", 64'(0), 64'(overflow_err));
   endtask

   task automatic xy_routing();
      start_test("xy_routing");
      route_one(8'd5, 8'd3);                          // east
      route_one(8'd1, 8'd3);                          // west
      route_one(8'd3, 8'd7);                          // north
      route_one(8'd3, 8'd0);                          // south
      route_one(8'd3, 8'd3);                          // local
      route_one(8'd6, 8'd0);                          // x goes first
   endtask

   task automatic multi_flit_packet();
      start_test("multi_flit_packet");
      send_flit(VC1, make_flit(HEAD, 8'd0, 8'd9));
      send_flit(VC1, make_flit(BODY, 8'd0, 8'd0));
      send_flit(VC1, make_flit(BODY, 8'd0, 8'd0));
      send_flit(VC1, make_flit(TAIL, 8'd0, 8'd0));
      repeat (4) grant(VC1);
   endtask

   task automatic vc_independence();
      start_test("vc_independence");
      send_flit(VC0, make_flit(HEAD, 8'd3, 8'd8));
      send_flit(VC1, make_flit(HEAD, 8'd3, 8'd1));
      send_flit(VC0, make_flit(TAIL, 8'd0, 8'd0));
      send_flit(VC1, make_flit(BODY, 8'd0, 8'd0));
      send_flit(VC1, make_flit(TAIL, 8'd0, 8'd0));
      repeat (3) begin
         grant(VC1);
         if (sw_req[0] !== 1'b1) mismatch("sw_req[0]", 64'(1), 64'(sw_req[0]));
      end
      repeat (2) grant(VC0);
   endtask

   task automatic backpressure();
      int start_credits;
      int start_valids;
      start_test("backpressure");
      start_credits = credits_seen[0];
      start_valids  = valids_seen[0];
      send_flit(VC0, make_flit(HEAD, 8'd3, 8'd3));
      send_flit(VC0, make_flit(BODY, 8'd0, 8'd0));
      send_flit(VC0, make_flit(BODY, 8'd0, 8'd0));
      send_flit(VC0, make_flit(TAIL, 8'd0, 8'd0));
      repeat (12) begin                               // nothing may leave without a grant
         @(negedge clk);
         if (out_valid !== '0) mismatch("out_valid", 64'(0), 64'(out_valid));
         if (credit_out !== '0) mismatch("credit_out", 64'(0), 64'(credit_out));
      end
      repeat (4) grant(VC0);
      if (credits_seen[0] - start_credits != 4)
         mismatch("credits", 64'(4), 64'(credits_seen[0] - start_credits));
      if (valids_seen[0] - start_valids != 4)
         mismatch("out_valid pulses", 64'(4), 64'(valids_seen[0] - start_valids));
   endtask

   task automatic overflow_drop();
      start_test("overflow_drop");
      send_flit(VC1, make_flit(SINGLE, 8'd7, 8'd3));
      send_flit(VC1, make_flit(SINGLE, 8'd3, 8'd7));
      send_flit(VC1, make_flit(SINGLE, 8'd0, 8'd3));
      send_flit(VC1, make_flit(SINGLE, 8'd3, 8'd0));
      @(negedge clk);
      if (overflow_err !== 1'b0) mismatch("overflow_err", 64'(0), 64'(overflow_err));
      send_flit(VC1, make_flit(SINGLE, 8'd9, 8'd9));  // vc already full
      @(negedge clk);
      if (overflow_err !== 1'b1) mismatch("overflow_err", 64'(1), 64'(overflow_err));
      repeat (4) grant(VC1);
      if (overflow_err !== 1'b1) mismatch("sticky overflow_err", 64'(1), 64'(overflow_err));
      if (sw_req[1] !== 1'b0) mismatch("sw_req[1]", 64'(0), 64'(sw_req[1]));
   endtask

   // --------------------
   // run
   initial begin
      void'($urandom(32'hd4f7_dfee));
      in_valid <= 1'b0;
      in_vc    <= '0;
      in_flit  <= '0;
      sw_gnt   <= '0;
      @(negedge rst);
      reset_state();
      xy_routing();
      multi_flit_packet();
      vc_independence();
      backpressure();
      overflow_drop();
      $display("%0d tests run, %0d errors", tests_run, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
design/noc_pkg.sv
design/flit_receiver.sv
design/vc_fifo.sv
design/vc_output.sv
design/input_buffer.sv
tb/tb_clock.sv
tb/input_buffer_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --timing
TOP       := input_buffer_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
PASS_MSG  := Regression passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
